//--- include/rob_cfg.svh
// Reorder buffer sizing, included by the RTL and by the testbench
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// Number of buffer entries
// Must stay a power of two so the binary pointers wrap for free
`define ROB_DEPTH 32

// Width of an entry index, log2 of the depth
// Also sizes the destination physical register field
`define ROB_IDX_W 5

`endif

//--- hdl/rob_pkg.sv
// Shared types for the reorder buffer, imported by the storage, interface and commit FSM
`include "rob_cfg.svh"

package rob_pkg;

    // Commit FSM states
    // Idle waits on a done head, write holds the Wishbone cycle until ack
    typedef enum logic {
        COMMIT_IDLE,
        COMMIT_WRITE
    } commit_state_e;

    // One buffer entry, valid bit lives outside in the storage
    typedef struct packed {
        // Fetch address of the instruction
        logic [31:0]            pc;
        // Raw instruction word, never decoded here
        logic [31:0]            inst;
        // Destination physical register
        logic [`ROB_IDX_W-1:0]  prd;
        // Result from the execution unit
        logic [31:0]            value;
        // Set once the result has been written
        logic                   done;
    } rob_entry_t;

endpackage

//--- hdl/rob_if.sv
// Bundle between pointer counter, entry storage and commit FSM inside the reorder buffer
`timescale 1ns/100ps
`include "rob_cfg.svh"

interface rob_if;
    import rob_pkg::*;

    // Allocation accepted this cycle
    logic                   alloc_fire;
    // Next free slot and oldest entry
    logic [`ROB_IDX_W-1:0]  tail_idx;
    logic [`ROB_IDX_W-1:0]  head_idx;
    // Head leaves the buffer this cycle
    logic                   retire;
    // Combinational view of the head slot
    logic                   head_valid;
    rob_entry_t             head_entry;

    // Counter owns the pointers and the allocate decision
    modport ctr (output alloc_fire, tail_idx, head_idx, input retire);

    // Storage follows the pointers and serves the head
    modport ram (input alloc_fire, tail_idx, head_idx, retire,
                 output head_valid, head_entry);

    // Commit FSM only looks at the head
    modport fsm (input head_valid, head_entry, output retire);

endinterface

//--- hdl/rob_ptr_ctr.sv
// Head and tail pointers with occupancy count, gives back-pressure to dispatch
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_ptr_ctr (
    input  logic clk_i,
    input  logic reset_i,
    input  logic alloc_valid_i,
    output logic full_o,
    output logic empty_o,
    rob_if.ctr   rif
);

    logic [`ROB_IDX_W-1:0] head_q;
    logic [`ROB_IDX_W-1:0] tail_q;
    // One bit wider so a full buffer is distinct from an empty one
    logic [`ROB_IDX_W:0]   count_q;

    assign full_o  = (count_q == (`ROB_IDX_W+1)'(`ROB_DEPTH));
    assign empty_o = (count_q == '0);

    // Only place that decides an allocation happens
    assign rif.alloc_fire = alloc_valid_i & ~full_o;
    assign rif.tail_idx   = tail_q;
    assign rif.head_idx   = head_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // Plain binary wrap, depth is a power of two
            if (rif.alloc_fire) begin
                tail_q <= tail_q + `ROB_IDX_W'(1);
            end
            if (rif.retire) begin
                head_q <= head_q + `ROB_IDX_W'(1);
            end

            // Both at once leaves the occupancy unchanged
            case ({rif.alloc_fire, rif.retire})
                2'b10:   count_q <= count_q + (`ROB_IDX_W+1)'(1);
                2'b01:   count_q <= count_q - (`ROB_IDX_W+1)'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // Commit FSM must never free a slot that was never filled
    a_no_retire_empty: assert property (
        @(posedge clk_i) disable iff (reset_i)
        rif.retire |-> !empty_o
    ) else $error("retire while buffer empty");

endmodule

//--- hdl/rob_entry_ram.sv
// Reorder buffer entry storage, written on allocate and completion, head read combinationally
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_entry_ram (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic [31:0]            alloc_pc_i,
    input  logic [31:0]            alloc_inst_i,
    input  logic [`ROB_IDX_W-1:0]  alloc_prd_i,
    input  logic                   cmpl_valid_i,
    input  logic [`ROB_IDX_W-1:0]  cmpl_idx_i,
    input  logic [31:0]            cmpl_value_i,
    rob_if.ram                     rif
);
    import rob_pkg::*;

    // Payload array and per-slot occupancy
    rob_entry_t              mem_q [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]   valid_q;

    // Head view for the commit FSM
    assign rif.head_valid = valid_q[rif.head_idx];
    assign rif.head_entry = mem_q[rif.head_idx];

    // Occupancy bits
    // Tail and head never alias here, a full buffer blocks alloc_fire
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            if (rif.alloc_fire) begin
                valid_q[rif.tail_idx] <= 1'b1;
            end
            if (rif.retire) begin
                valid_q[rif.head_idx] <= 1'b0;
            end
        end
    end

    // Payload writes
    always_ff @(posedge clk_i) begin
        // New entry starts not done, value is filled in later
        if (rif.alloc_fire) begin
            mem_q[rif.tail_idx].pc   <= alloc_pc_i;
            mem_q[rif.tail_idx].inst <= alloc_inst_i;
            mem_q[rif.tail_idx].prd  <= alloc_prd_i;
            mem_q[rif.tail_idx].done <= 1'b0;
        end
        // Result from execution, any order
        if (cmpl_valid_i) begin
            mem_q[cmpl_idx_i].value <= cmpl_value_i;
            mem_q[cmpl_idx_i].done  <= 1'b1;
        end
    end

    // Completion only for a slot that was allocated on an earlier edge
    a_cmpl_valid_slot: assert property (
        @(posedge clk_i) disable iff (reset_i)
        cmpl_valid_i |-> valid_q[cmpl_idx_i]
    ) else $error("completion to slot %0d which is not valid", cmpl_idx_i);

    // Counter pointers must agree with the occupancy bits
    a_alloc_free_slot: assert property (
        @(posedge clk_i) disable iff (reset_i)
        rif.alloc_fire |-> !valid_q[rif.tail_idx]
    ) else $error("allocation over live slot %0d", rif.tail_idx);

endmodule

//--- hdl/rob_commit_fsm.sv
// Retirement FSM, writes the done head entry to the register file as a Wishbone master
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_commit_fsm (
    input  logic                   clk_i,
    input  logic                   reset_i,
    rob_if.fsm                     rif,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output logic [`ROB_IDX_W-1:0]  wb_adr_o,
    output logic [31:0]            wb_dat_o,
    input  logic                   wb_ack_i,
    output logic [31:0]            commit_pc_o,
    output logic [31:0]            commit_inst_o
);
    import rob_pkg::*;

    commit_state_e state_q;
    logic          cyc_q;
    logic          stb_q;

    // Bus payload, only meaningful while cyc is up
    logic [`ROB_IDX_W-1:0] adr_q;
    logic [31:0]           dat_q;
    logic [31:0]           pc_q;
    logic [31:0]           inst_q;

    logic head_ready;

    // Oldest entry has its result
    assign head_ready = rif.head_valid & rif.head_entry.done;

    // Slot freed on the ack edge itself
    assign rif.retire = (state_q == COMMIT_WRITE) & wb_ack_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= COMMIT_IDLE;
            cyc_q   <= 1'b0;
            stb_q   <= 1'b0;
        end else begin
            case (state_q)
                COMMIT_IDLE: begin
                    if (head_ready) begin
                        state_q <= COMMIT_WRITE;
                        cyc_q   <= 1'b1;
                        stb_q   <= 1'b1;
                    end
                end
                COMMIT_WRITE: begin
                    // Hold the bus until the register file answers
                    if (wb_ack_i) begin
                        state_q <= COMMIT_IDLE;
                        cyc_q   <= 1'b0;
                        stb_q   <= 1'b0;
                    end
                end
                default: begin
                    state_q <= COMMIT_IDLE;
                    cyc_q   <= 1'b0;
                    stb_q   <= 1'b0;
                end
            endcase
        end
    end

    // Latch the head when the write starts
    always_ff @(posedge clk_i) begin
        if (state_q == COMMIT_IDLE && head_ready) begin
            adr_q  <= rif.head_entry.prd;
            dat_q  <= rif.head_entry.value;
            pc_q   <= rif.head_entry.pc;
            inst_q <= rif.head_entry.inst;
        end
    end

    assign wb_cyc_o      = cyc_q;
    assign wb_stb_o      = stb_q;
    // Commit only ever writes
    assign wb_we_o       = cyc_q;
    assign wb_adr_o      = adr_q;
    assign wb_dat_o      = dat_q;
    assign commit_pc_o   = pc_q;
    assign commit_inst_o = inst_q;

    // Classic Wishbone, strobe only inside a cycle
    a_stb_in_cyc: assert property (
        @(posedge clk_i) disable iff (reset_i)
        wb_stb_o |-> wb_cyc_o
    ) else $error("wb_stb_o high without wb_cyc_o");

    // Request and payload held steady until acked
    a_hold_until_ack: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o))
    ) else $error("Wishbone request dropped or changed before ack");

endmodule

//--- hdl/rob_top.sv
// Reorder buffer top level, dispatch and completion in, Wishbone commit to the register file out
`timescale 1ns/100ps
`include "rob_cfg.svh"

module rob_top (
    input  logic                   clk_i,
    input  logic                   reset_i,
    // Dispatch, one entry per cycle in program order
    input  logic                   alloc_valid_i,
    input  logic [31:0]            alloc_pc_i,
    input  logic [31:0]            alloc_inst_i,
    input  logic [`ROB_IDX_W-1:0]  alloc_prd_i,
    output logic [`ROB_IDX_W-1:0]  alloc_idx_o,
    output logic                   full_o,
    output logic                   empty_o,
    // Completion by index, any order
    input  logic                   cmpl_valid_i,
    input  logic [`ROB_IDX_W-1:0]  cmpl_idx_i,
    input  logic [31:0]            cmpl_value_i,
    // Register file write port
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output logic [`ROB_IDX_W-1:0]  wb_adr_o,
    output logic [31:0]            wb_dat_o,
    input  logic                   wb_ack_i,
    // Retiring instruction, valid with wb_cyc_o
    output logic [31:0]            commit_pc_o,
    output logic [31:0]            commit_inst_o
);

    rob_if rif ();

    // Index handed to an allocation in this cycle
    assign alloc_idx_o = rif.tail_idx;

    rob_ptr_ctr u_ptr_ctr (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .alloc_valid_i (alloc_valid_i),
        .full_o        (full_o),
        .empty_o       (empty_o),
        .rif           (rif.ctr)
    );

    rob_entry_ram u_entry_ram (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .alloc_pc_i   (alloc_pc_i),
        .alloc_inst_i (alloc_inst_i),
        .alloc_prd_i  (alloc_prd_i),
        .cmpl_valid_i (cmpl_valid_i),
        .cmpl_idx_i   (cmpl_idx_i),
        .cmpl_value_i (cmpl_value_i),
        .rif          (rif.ram)
    );

    rob_commit_fsm u_commit_fsm (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .rif           (rif.fsm),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_we_o       (wb_we_o),
        .wb_adr_o      (wb_adr_o),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_i      (wb_ack_i),
        .commit_pc_o   (commit_pc_o),
        .commit_inst_o (commit_inst_o)
    );

endmodule

//--- tb/tb_rob_top.sv
// Testbench for the reorder buffer that runs a stimulus table and checks each Wishbone commit
`timescale 1ns/100ps
`include "rob_cfg.svh"

module tb_rob_top;
    import rob_pkg::*;

    typedef enum {OP_IDLE, OP_ALLOC, OP_CMPL} op_e;

    // DUT ports
    logic                  clk_i;
    logic                  reset_i;
    logic                  alloc_valid_i;
    logic [31:0]           alloc_pc_i;
    logic [31:0]           alloc_inst_i;
    logic [`ROB_IDX_W-1:0] alloc_prd_i;
    logic [`ROB_IDX_W-1:0] alloc_idx_o;
    logic                  full_o;
    logic                  empty_o;
    logic                  cmpl_valid_i;
    logic [`ROB_IDX_W-1:0] cmpl_idx_i;
    logic [31:0]           cmpl_value_i;
    logic                  wb_cyc_o;
    logic                  wb_stb_o;
    logic                  wb_we_o;
    logic [`ROB_IDX_W-1:0] wb_adr_o;
    logic [31:0]           wb_dat_o;
    logic                  wb_ack_i = 1'b0;
    logic [31:0]           commit_pc_o;
    logic [31:0]           commit_inst_o;

    // Stimulus table rows
    // Offset is the program order number of the target
    op_e         tbl_op [256];
    logic [31:0] tbl_pc [256];
    logic [31:0] tbl_inst [256];
    logic [31:0] tbl_val [256];
    logic [`ROB_IDX_W-1:0] tbl_prd [256];
    int          tbl_off [256];
    int          n_rows = 0;
    bit          table_built = 0;

    // Scoreboard records by program order number
    logic [`ROB_IDX_W-1:0] rec_idx [256];
    logic [`ROB_IDX_W-1:0] rec_prd [256];
    logic [31:0]           rec_pc [256];
    logic [31:0]           rec_inst [256];
    logic [31:0]           rec_val [256];
    bit                    rec_done [256];
    int                    sb_q [$];
    int                    alloc_count = 0;
    int                    retire_count = 0;
    int                    cmpl_seq = 0;
    int                    ack_wait = 0;
    bit                    saw_full = 0;
    bit                    ack_armed = 0;
    // Expected state of the Wishbone request
    bit                    write_busy = 0;

    // FSM state for waves
    commit_state_e fsm_state;
    assign fsm_state = DUT.u_commit_fsm.state_q;

    rob_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run("Check failed");
        end
    endtask

    task automatic add_row(input op_e op, input int seq, input logic [31:0] val);
        tbl_op[n_rows]   = op;
        tbl_off[n_rows]  = seq;
        // Per entry payload that is easy to tell apart on the bus
        tbl_pc[n_rows]   = 32'h0000_1000 + 32'(seq << 2);
        tbl_inst[n_rows] = 32'h0000_0013 | 32'(seq << 7);
        tbl_prd[n_rows]  = `ROB_IDX_W'((seq * 7 + 3) % 32);
        tbl_val[n_rows]  = val;
        n_rows = n_rows + 1;
    endtask

    task automatic apply_row(input int r);
        @(negedge clk_i);
        alloc_valid_i = 1'b0;
        cmpl_valid_i  = 1'b0;
        case (tbl_op[r])
            OP_ALLOC: begin
                alloc_valid_i = 1'b1;
                alloc_pc_i    = tbl_pc[r];
                alloc_inst_i  = tbl_inst[r];
                alloc_prd_i   = tbl_prd[r];
                // Retry each cycle while full with the tail held
                while (full_o) begin
                    saw_full = 1'b1;
                    check_value("alloc_idx_o while full", 32'(alloc_idx_o),
                                32'(alloc_count % `ROB_DEPTH));
                    @(negedge clk_i);
                end
            end
            OP_CMPL: begin
                cmpl_valid_i = 1'b1;
                cmpl_idx_i   = rec_idx[tbl_off[r]];
                cmpl_value_i = tbl_val[r];
                cmpl_seq     = tbl_off[r];
            end
            default: ;
        endcase
    endtask

    // Register file slave acks after 0 to 3 wait cycles
    initial begin
        void'($urandom(32'h8c7d));
        forever begin
            @(negedge clk_i);
            if (reset_i) begin
                wb_ack_i  = 1'b0;
                ack_armed = 1'b0;
            end else if (wb_ack_i) begin
                wb_ack_i = 1'b0;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (!ack_armed) begin
                    ack_wait  = int'($urandom % 4);
                    ack_armed = 1'b1;
                end
                if (ack_wait == 0) begin
                    wb_ack_i  = 1'b1;
                    ack_armed = 1'b0;
                end else begin
                    ack_wait = ack_wait - 1;
                end
            end
        end
    end

    // Monitor sees pre-edge values of the DUT
    always @(posedge clk_i) begin
        if (!reset_i) begin
            check_value("full_o", 32'(full_o),
                        32'(alloc_count - retire_count == `ROB_DEPTH));
            check_value("empty_o", 32'(empty_o), 32'(alloc_count == retire_count));
            check_value("wb_cyc_o", 32'(wb_cyc_o), 32'(write_busy));
            check_value("wb_stb_o", 32'(wb_stb_o), 32'(write_busy));
            // A write starts one edge after the head is seen done and ends on ack
            if (write_busy) begin
                write_busy = !wb_ack_i;
            end else if (sb_q.size() != 0) begin
                write_busy = rec_done[sb_q[0]];
            end
            if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
                if (sb_q.size() == 0) begin
                    stop_run("Wishbone write with no outstanding entry");
                end else begin
                    int seq;
                    seq = sb_q.pop_front();
                    // Record must be done and match the payload in program order
                    check_value("completion before retire", 32'(rec_done[seq]), 32'd1);
                    check_value("wb_we_o", 32'(wb_we_o), 32'd1);
                    check_value("wb_adr_o", 32'(wb_adr_o), 32'(rec_prd[seq]));
                    check_value("wb_dat_o", wb_dat_o, rec_val[seq]);
                    check_value("commit_pc_o", commit_pc_o, rec_pc[seq]);
                    check_value("commit_inst_o", commit_inst_o, rec_inst[seq]);
                    retire_count = retire_count + 1;
                end
            end
            if (cmpl_valid_i) begin
                rec_val[cmpl_seq]  = cmpl_value_i;
                rec_done[cmpl_seq] = 1'b1;
            end
            if (alloc_valid_i && !full_o) begin
                // Indices count up from zero and wrap at the depth
                check_value("alloc_idx_o", 32'(alloc_idx_o), 32'(alloc_count % `ROB_DEPTH));
                rec_idx[alloc_count]  = alloc_idx_o;
                rec_pc[alloc_count]   = alloc_pc_i;
                rec_inst[alloc_count] = alloc_inst_i;
                rec_prd[alloc_count]  = alloc_prd_i;
                rec_done[alloc_count] = 1'b0;
                sb_q.push_back(alloc_count);
                alloc_count = alloc_count + 1;
            end
        end
    end

    // Watchdog allows 20 cycles per table row
    initial begin
        wait (table_built);
        repeat (n_rows * 20) #100;
        stop_run("Watchdog expired, the run hung");
    end

    initial begin
        reset_i       = 1'b1;
        alloc_valid_i = 1'b0;
        alloc_pc_i    = '0;
        alloc_inst_i  = '0;
        alloc_prd_i   = '0;
        cmpl_valid_i  = 1'b0;
        cmpl_idx_i    = '0;
        cmpl_value_i  = '0;

        // Four entries and three idle cycles before completing them in reverse
        for (int s = 0; s < 4; s++) begin
            add_row(OP_ALLOC, s, '0);
        end
        for (int k = 0; k < 3; k++) begin
            add_row(OP_IDLE, 0, '0);
        end
        for (int s = 3; s >= 0; s--) begin
            add_row(OP_CMPL, s, 32'hA500_0000 + 32'(s * 273));
        end
        for (int k = 0; k < 24; k++) begin
            add_row(OP_IDLE, 0, '0);
        end
        // Fill all slots and free the oldest while one more allocation waits
        for (int s = 4; s < 36; s++) begin
            add_row(OP_ALLOC, s, '0);
        end
        add_row(OP_CMPL, 4, 32'h5A5A_0004);
        add_row(OP_ALLOC, 36, '0);
        // Scrambled completion of everything still in flight
        for (int k = 0; k < 32; k++) begin
            add_row(OP_CMPL, (k * 5) % 32 + 5, 32'hC000_0000 + 32'(k * 4099));
        end
        table_built = 1'b1;

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        check_value("empty_o after reset", 32'(empty_o), 32'd1);
        check_value("full_o after reset", 32'(full_o), 32'd0);
        check_value("wb_cyc_o after reset", 32'(wb_cyc_o), 32'd0);

        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        @(negedge clk_i);
        alloc_valid_i = 1'b0;
        cmpl_valid_i  = 1'b0;

        // Buffer must read empty after the drain
        while (sb_q.size() != 0) @(negedge clk_i);
        @(negedge clk_i);
        check_value("empty_o after drain", 32'(empty_o), 32'd1);

        if (retire_count == alloc_count && retire_count == 37 && saw_full) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_run("Commit count wrong or the buffer never filled");
        end
    end

endmodule

//--- rob_top.f
+incdir+include
hdl/rob_pkg.sv
hdl/rob_if.sv
hdl/rob_ptr_ctr.sv
hdl/rob_entry_ram.sv
hdl/rob_commit_fsm.sv
hdl/rob_top.sv
tb/tb_rob_top.sv

//--- Makefile
TOP = tb_rob_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rob_top.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
